/* source/vec_isa_pkg.sv */
`default_nettype none

package vec_isa_pkg;

  //////////////////////////////////////////////////
  // Architectural sizes
  //////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 32;

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [4:0]           vreg_idx_t;

  // Vector operations seen by the scalar core
  // VV forms compute vs2 op vs1, VADD_VX computes vs2 + scalar
  // VEXT_X reads vs2 at element (scalar mod VLMAX)
  typedef enum logic [2:0] {
    VSETVL,
    VID,
    VADD_VV,
    VSUB_VV,
    VAND_VV,
    VOR_VV,
    VADD_VX,
    VEXT_X
  } vec_op_e;

  // Request from the core
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } acc_req_t;

  // Response to the core
  typedef struct packed {
    elem_t result;
  } acc_resp_t;

endpackage

`default_nettype wire

/* source/vec_uarch_pkg.sv */
`default_nettype none

package vec_uarch_pkg;

  // Vector length, enough for VLMAX up to 65535
  typedef logic [15:0] vl_t;

  //////////////////////////////////////////////////
  // Internal instruction
  //////////////////////////////////////////////////

  // Dispatcher to sequencer and sequencer to lanes
  typedef struct packed {
    vec_isa_pkg::vec_op_e   op;
    vec_isa_pkg::vreg_idx_t vd;
    vec_isa_pkg::vreg_idx_t vs1;
    vec_isa_pkg::vreg_idx_t vs2;
    vec_isa_pkg::elem_t     scalar;
    vl_t                    vl;
  } vinsn_t;

  // Sequencer FSM
  typedef enum logic {
    IDLE,
    BUSY
  } seq_state_e;

endpackage

`default_nettype wire

/* source/vec_lane_vrf.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_lane_vrf #(
  parameter  int unsigned VLEN         = 256,
  parameter  int unsigned NrLanes      = 4,
  localparam int unsigned VLMAX        = VLEN / vec_isa_pkg::ElemWidth,
  localparam int unsigned ElemsPerLane = VLMAX / NrLanes,
  localparam int unsigned SlotW        = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Two read ports sharing one slot
  input  vec_isa_pkg::vreg_idx_t rd_a_reg_i,
  input  vec_isa_pkg::vreg_idx_t rd_b_reg_i,
  input  logic [SlotW-1:0]       rd_slot_i,
  output vec_isa_pkg::elem_t     rd_a_data_o,
  output vec_isa_pkg::elem_t     rd_b_data_o,
  // Write port
  input  logic                   wr_en_i,
  input  vec_isa_pkg::vreg_idx_t wr_reg_i,
  input  logic [SlotW-1:0]       wr_slot_i,
  input  vec_isa_pkg::elem_t     wr_data_i
);

  vec_isa_pkg::elem_t mem_q [vec_isa_pkg::NrVRegs][ElemsPerLane];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < vec_isa_pkg::NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          mem_q[r][s] <= '0;
        end
      end
    end else if (wr_en_i) begin
      mem_q[wr_reg_i][wr_slot_i] <= wr_data_i;
    end
  end

  assign rd_a_data_o = mem_q[rd_a_reg_i][rd_slot_i];
  assign rd_b_data_o = mem_q[rd_b_reg_i][rd_slot_i];

endmodule

`default_nettype wire

/* source/vec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned VLEN         = 256,
  parameter  int unsigned LaneId       = 0,
  localparam int unsigned VLMAX        = VLEN / vec_isa_pkg::ElemWidth,
  localparam int unsigned ElemsPerLane = VLMAX / NrLanes,
  localparam int unsigned SlotW        = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  vec_uarch_pkg::vinsn_t pe_req_i,
  input  logic                  pe_req_valid_i,
  output logic                  done_o,
  output vec_isa_pkg::elem_t    scalar_o,
  output logic                  scalar_valid_o
);

  localparam int unsigned LaneBits = $clog2(NrLanes);

  typedef logic [SlotW-1:0] slot_t;
  typedef logic [SlotW:0]   cnt_t;

  vec_uarch_pkg::vinsn_t insn_q;
  logic                  busy_q;
  cnt_t                  slot_q;
  cnt_t                  n_active;
  logic [16:0]           act_num;
  logic [31:0]           ext_idx;
  logic                  ext_own;
  slot_t                 ext_slot;
  logic                  is_ext;
  logic                  last;
  logic                  wr_en;
  slot_t                 rd_slot;
  vec_isa_pkg::elem_t    rd_a;
  vec_isa_pkg::elem_t    rd_b;
  vec_isa_pkg::elem_t    vid_val;
  vec_isa_pkg::elem_t    alu_res;

  //////////////////////////////////////////////////
  // Element bookkeeping
  //////////////////////////////////////////////////

  // Lane-local slots whose global index is below vl
  assign act_num = (insn_q.vl > LaneId) ?
                   (17'(insn_q.vl) - 17'(LaneId) + 17'(NrLanes - 1)) : '0;
  assign n_active = cnt_t'(act_num >> LaneBits);

  // Extract index wraps at VLMAX
  assign ext_idx  = insn_q.scalar % VLMAX;
  assign ext_own  = (ext_idx % NrLanes) == LaneId;
  assign ext_slot = slot_t'(ext_idx / NrLanes);

  assign is_ext = insn_q.op == vec_isa_pkg::VEXT_X;
  assign last   = is_ext || (slot_q == n_active);
  assign wr_en  = busy_q && !last;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      slot_q <= '0;
    end else begin
      if (pe_req_valid_i) begin
        busy_q <= 1'b1;
        slot_q <= '0;
      end else if (busy_q) begin
        if (last) begin
          busy_q <= 1'b0;
        end else begin
          slot_q <= slot_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      insn_q <= pe_req_i;
    end
  end

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  // Global element index of the current slot
  assign vid_val = vec_isa_pkg::elem_t'(slot_q * NrLanes + LaneId);

  always_comb begin
    case (insn_q.op)
      vec_isa_pkg::VID:     alu_res = vid_val;
      vec_isa_pkg::VADD_VV: alu_res = rd_b + rd_a;
      vec_isa_pkg::VSUB_VV: alu_res = rd_b - rd_a;
      vec_isa_pkg::VAND_VV: alu_res = rd_b & rd_a;
      vec_isa_pkg::VOR_VV:  alu_res = rd_b | rd_a;
      vec_isa_pkg::VADD_VX: alu_res = rd_b + insn_q.scalar;
      default:              alu_res = rd_b;
    endcase
  end

  assign rd_slot = is_ext ? ext_slot : slot_q[SlotW-1:0];

  vec_lane_vrf #(
    .VLEN   (VLEN   ),
    .NrLanes(NrLanes)
  ) i_vrf (
    .clk_i      (clk_i             ),
    .rst_n_i    (rst_n_i           ),
    .rd_a_reg_i (insn_q.vs1        ),
    .rd_b_reg_i (insn_q.vs2        ),
    .rd_slot_i  (rd_slot           ),
    .rd_a_data_o(rd_a              ),
    .rd_b_data_o(rd_b              ),
    .wr_en_i    (wr_en             ),
    .wr_reg_i   (insn_q.vd         ),
    .wr_slot_i  (slot_q[SlotW-1:0] ),
    .wr_data_i  (alu_res           )
  );

  assign done_o         = busy_q && last;
  assign scalar_o       = rd_b;
  assign scalar_valid_o = busy_q && is_ext && ext_own;

endmodule

`default_nettype wire

/* source/vec_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Dispatcher
  input  vec_uarch_pkg::vinsn_t               seq_req_i,
  input  logic                                seq_req_valid_i,
  output logic                                seq_req_ready_o,
  output vec_isa_pkg::elem_t                  seq_resp_o,
  output logic                                seq_resp_valid_o,
  // Lanes
  output vec_uarch_pkg::vinsn_t               pe_req_o,
  output logic                                pe_req_valid_o,
  input  logic [NrLanes-1:0]                  lane_done_i,
  input  vec_isa_pkg::elem_t [NrLanes-1:0]    lane_scalar_i,
  input  logic [NrLanes-1:0]                  lane_scalar_valid_i
);

  vec_uarch_pkg::seq_state_e state_q;
  vec_uarch_pkg::vinsn_t     insn_q;
  logic                      pe_valid_q;
  logic                      resp_valid_q;
  logic [NrLanes-1:0]        done_q;
  logic [NrLanes-1:0]        done_d;
  vec_isa_pkg::elem_t        scalar_q;
  vec_isa_pkg::elem_t        scalar_sel;
  logic                      scalar_hit;

  assign done_d = done_q | lane_done_i;

  // At most one lane owns the extracted element
  always_comb begin
    scalar_sel = '0;
    scalar_hit = 1'b0;
    for (int l = 0; l < NrLanes; l++) begin
      if (lane_scalar_valid_i[l]) begin
        scalar_sel = lane_scalar_i[l];
        scalar_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= vec_uarch_pkg::IDLE;
      pe_valid_q   <= 1'b0;
      resp_valid_q <= 1'b0;
      done_q       <= '0;
      scalar_q     <= '0;
    end else begin
      pe_valid_q   <= 1'b0;
      resp_valid_q <= 1'b0;
      case (state_q)
        vec_uarch_pkg::IDLE: begin
          if (seq_req_valid_i) begin
            state_q    <= vec_uarch_pkg::BUSY;
            pe_valid_q <= 1'b1;
            done_q     <= '0;
            scalar_q   <= '0;
          end
        end
        vec_uarch_pkg::BUSY: begin
          done_q <= done_d;
          if (scalar_hit) begin
            scalar_q <= scalar_sel;
          end
          // All lanes finished
          if (&done_d) begin
            state_q      <= vec_uarch_pkg::IDLE;
            resp_valid_q <= 1'b1;
          end
        end
        default: state_q <= vec_uarch_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (seq_req_valid_i && state_q == vec_uarch_pkg::IDLE) begin
      insn_q <= seq_req_i;
    end
  end

  assign seq_req_ready_o  = state_q == vec_uarch_pkg::IDLE;
  assign seq_resp_o       = scalar_q;
  assign seq_resp_valid_o = resp_valid_q;
  assign pe_req_o         = insn_q;
  assign pe_req_valid_o   = pe_valid_q;

endmodule

`default_nettype wire

/* source/vec_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher #(
  parameter int unsigned VLEN = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Core request
  input  vec_isa_pkg::acc_req_t   acc_req_i,
  input  logic                    acc_req_valid_i,
  output logic                    acc_req_ready_o,
  // Core response
  output vec_isa_pkg::acc_resp_t  acc_resp_o,
  output logic                    acc_resp_valid_o,
  input  logic                    acc_resp_ready_i,
  // Sequencer
  output vec_uarch_pkg::vinsn_t   seq_req_o,
  output logic                    seq_req_valid_o,
  input  logic                    seq_req_ready_i,
  input  vec_isa_pkg::elem_t      seq_resp_i,
  input  logic                    seq_resp_valid_i
);

  localparam int unsigned VLMAX = VLEN / vec_isa_pkg::ElemWidth;

  logic                   busy_q;
  logic                   resp_valid_q;
  logic                   seq_valid_q;
  vec_uarch_pkg::vl_t     vl_q;
  vec_uarch_pkg::vl_t     new_vl;
  vec_isa_pkg::acc_resp_t resp_q;
  vec_uarch_pkg::vinsn_t  seq_req_q;
  logic                   req_fire;
  logic                   resp_fire;
  logic                   is_setvl;

  // One request outstanding until its response leaves
  assign req_fire  = acc_req_valid_i && !busy_q;
  assign resp_fire = resp_valid_q && acc_resp_ready_i;
  assign is_setvl  = acc_req_i.op == vec_isa_pkg::VSETVL;

  // Clamp requested length to VLMAX
  assign new_vl = (acc_req_i.scalar > VLMAX) ? vec_uarch_pkg::vl_t'(VLMAX)
                                             : vec_uarch_pkg::vl_t'(acc_req_i.scalar);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      resp_valid_q <= 1'b0;
      seq_valid_q  <= 1'b0;
      vl_q         <= '0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
        if (is_setvl) begin
          vl_q         <= new_vl;
          resp_valid_q <= 1'b1;
        end else begin
          seq_valid_q <= 1'b1;
        end
      end
      if (seq_valid_q && seq_req_ready_i) begin
        seq_valid_q <= 1'b0;
      end
      if (seq_resp_valid_i) begin
        resp_valid_q <= 1'b1;
      end
      if (resp_fire) begin
        resp_valid_q <= 1'b0;
        busy_q       <= 1'b0;
      end
    end
  end

  // Result and forwarded instruction
  always_ff @(posedge clk_i) begin
    if (req_fire && is_setvl) begin
      resp_q.result <= vec_isa_pkg::elem_t'(new_vl);
    end else if (seq_resp_valid_i) begin
      resp_q.result <= seq_resp_i;
    end
    if (req_fire) begin
      seq_req_q.op     <= acc_req_i.op;
      seq_req_q.vd     <= acc_req_i.vd;
      seq_req_q.vs1    <= acc_req_i.vs1;
      seq_req_q.vs2    <= acc_req_i.vs2;
      seq_req_q.scalar <= acc_req_i.scalar;
      seq_req_q.vl     <= vl_q;
    end
  end

  assign acc_req_ready_o  = !busy_q;
  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = resp_valid_q;
  assign seq_req_o        = seq_req_q;
  assign seq_req_valid_o  = seq_valid_q;

endmodule

`default_nettype wire

/* source/vec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_top #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  vec_isa_pkg::acc_req_t  acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  output vec_isa_pkg::acc_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i
);

  //////////////////////////////////////////////////
  // Dispatcher
  //////////////////////////////////////////////////

  vec_uarch_pkg::vinsn_t seq_req;
  logic                  seq_req_valid;
  logic                  seq_req_ready;
  vec_isa_pkg::elem_t    seq_resp;
  logic                  seq_resp_valid;

  vec_dispatcher #(
    .VLEN(VLEN)
  ) i_dispatcher (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i),
    .seq_req_o       (seq_req         ),
    .seq_req_valid_o (seq_req_valid   ),
    .seq_req_ready_i (seq_req_ready   ),
    .seq_resp_i      (seq_resp        ),
    .seq_resp_valid_i(seq_resp_valid  )
  );

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  vec_uarch_pkg::vinsn_t            pe_req;
  logic                             pe_req_valid;
  logic [NrLanes-1:0]               lane_done;
  vec_isa_pkg::elem_t [NrLanes-1:0] lane_scalar;
  logic [NrLanes-1:0]               lane_scalar_valid;

  vec_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i              (clk_i            ),
    .rst_n_i            (rst_n_i          ),
    .seq_req_i          (seq_req          ),
    .seq_req_valid_i    (seq_req_valid    ),
    .seq_req_ready_o    (seq_req_ready    ),
    .seq_resp_o         (seq_resp         ),
    .seq_resp_valid_o   (seq_resp_valid   ),
    .pe_req_o           (pe_req           ),
    .pe_req_valid_o     (pe_req_valid     ),
    .lane_done_i        (lane_done        ),
    .lane_scalar_i      (lane_scalar      ),
    .lane_scalar_valid_i(lane_scalar_valid)
  );

  // Lanes
  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .VLEN   (VLEN   ),
      .LaneId (lane   )
    ) i_lane (
      .clk_i         (clk_i                  ),
      .rst_n_i       (rst_n_i                ),
      .pe_req_i      (pe_req                 ),
      .pe_req_valid_i(pe_req_valid           ),
      .done_o        (lane_done[lane]        ),
      .scalar_o      (lane_scalar[lane]      ),
      .scalar_valid_o(lane_scalar_valid[lane])
    );
  end : gen_lanes

endmodule

`default_nettype wire

/* tb/vec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_tb;

  localparam int unsigned NrLanes = 4;
  localparam int unsigned VLEN    = 256;
  localparam int unsigned VLMAX   = VLEN / vec_isa_pkg::ElemWidth;

  // About 130 requests in all, budgeted at 300 for margin
  localparam int unsigned RequestBudget = 300;
  localparam int unsigned TimeoutCycles = RequestBudget * (VLMAX / NrLanes + 10) + 400;

  logic                   clk;
  logic                   rst_n;
  vec_isa_pkg::acc_req_t  acc_req;
  logic                   acc_req_valid;
  logic                   acc_req_ready;
  vec_isa_pkg::acc_resp_t acc_resp;
  logic                   acc_resp_valid;
  logic                   acc_resp_ready;

  int unsigned n_checks  = 0;
  int unsigned n_errors  = 0;
  int unsigned cycle_cnt = 0;
  logic [31:0] lfsr_q    = 32'h5892;

  // Reference state
  int unsigned        model_vl;
  vec_isa_pkg::elem_t model_vrf [vec_isa_pkg::NrVRegs][VLMAX];

  vec_top #(
    .NrLanes(NrLanes),
    .VLEN   (VLEN   )
  ) dut_i (
    .clk_i           (clk           ),
    .rst_n_i         (rst_n         ),
    .acc_req_i       (acc_req       ),
    .acc_req_valid_i (acc_req_valid ),
    .acc_req_ready_o (acc_req_ready ),
    .acc_resp_o      (acc_resp      ),
    .acc_resp_valid_o(acc_resp_valid),
    .acc_resp_ready_i(acc_resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the DUT stopped responding after %0d cycles", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int b = 0; b < n; b++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic drive_req(input vec_isa_pkg::acc_req_t req);
    @(posedge clk);
    acc_req       <= req;
    acc_req_valid <= 1'b1;
    @(negedge clk);
    while (!acc_req_ready) @(negedge clk);
    @(posedge clk);
    acc_req_valid <= 1'b0;
  endtask

  task automatic wait_resp(output vec_isa_pkg::elem_t result);
    @(negedge clk);
    while (!acc_resp_valid) @(negedge clk);
    result = acc_resp.result;
  endtask

  task automatic send_insn(input vec_isa_pkg::vec_op_e op, input vec_isa_pkg::vreg_idx_t vd,
                           input vec_isa_pkg::vreg_idx_t vs1,
                           input vec_isa_pkg::vreg_idx_t vs2,
                           input vec_isa_pkg::elem_t scalar,
                           output vec_isa_pkg::elem_t result);
    vec_isa_pkg::acc_req_t req;
    req.op     = op;
    req.vd     = vd;
    req.vs1    = vs1;
    req.vs2    = vs2;
    req.scalar = scalar;
    drive_req(req);
    wait_resp(result);
  endtask

  // Elements below vl change, the tail stays
  function automatic void apply_to_model(input vec_isa_pkg::vec_op_e op,
                                         input vec_isa_pkg::vreg_idx_t vd,
                                         input vec_isa_pkg::vreg_idx_t vs1,
                                         input vec_isa_pkg::vreg_idx_t vs2,
                                         input vec_isa_pkg::elem_t scalar);
    if (op == vec_isa_pkg::VSETVL) begin
      model_vl = (scalar > VLMAX) ? VLMAX : scalar;
    end
    for (int i = 0; i < model_vl; i++) begin
      case (op)
        vec_isa_pkg::VID:     model_vrf[vd][i] = i;
        vec_isa_pkg::VADD_VV: model_vrf[vd][i] = model_vrf[vs2][i] + model_vrf[vs1][i];
        vec_isa_pkg::VSUB_VV: model_vrf[vd][i] = model_vrf[vs2][i] - model_vrf[vs1][i];
        vec_isa_pkg::VAND_VV: model_vrf[vd][i] = model_vrf[vs2][i] & model_vrf[vs1][i];
        vec_isa_pkg::VOR_VV:  model_vrf[vd][i] = model_vrf[vs2][i] | model_vrf[vs1][i];
        vec_isa_pkg::VADD_VX: model_vrf[vd][i] = model_vrf[vs2][i] + scalar;
        default: ;
      endcase
    end
  endfunction

  task automatic issue_and_check(input vec_isa_pkg::vec_op_e op,
                                 input vec_isa_pkg::vreg_idx_t vd,
                                 input vec_isa_pkg::vreg_idx_t vs1,
                                 input vec_isa_pkg::vreg_idx_t vs2,
                                 input vec_isa_pkg::elem_t scalar);
    vec_isa_pkg::elem_t result;
    vec_isa_pkg::elem_t expected;
    // Vector work answers with zero
    expected = '0;
    if (op == vec_isa_pkg::VSETVL) begin
      expected = (scalar > VLMAX) ? VLMAX : scalar;
    end else if (op == vec_isa_pkg::VEXT_X) begin
      expected = model_vrf[vs2][scalar % VLMAX];
    end
    send_insn(op, vd, vs1, vs2, scalar, result);
    check_value($sformatf("acc_resp_o.result op=%0d vs2=%0d scalar=0x%0h", op, vs2, scalar),
                result, expected);
    apply_to_model(op, vd, vs1, vs2, scalar);
  endtask

  // Index above VLMAX wraps around
  task automatic check_reg(input vec_isa_pkg::vreg_idx_t vreg);
    for (int i = 0; i < VLMAX; i++) begin
      issue_and_check(vec_isa_pkg::VEXT_X, '0, '0, vreg, i + VLMAX * rand_bits(2));
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    for (int n = 0; n < 16; n++) begin
      issue_and_check(vec_isa_pkg::VEXT_X, '0, '0, rand_bits(5), rand_bits(8));
    end
  endtask

  task automatic test_setvl_clamp();
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, 32'd0);
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, VLMAX);
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, VLMAX + 1);
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, 32'hFFFF_FFFF);
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, 32'h0001_0003);
    for (int n = 0; n < 3; n++) begin
      issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, rand_bits(4));
      issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, rand_bits(32));
    end
  endtask

  task automatic test_full_length_alu();
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, VLMAX);
    issue_and_check(vec_isa_pkg::VID, 5'd1, '0, '0, '0);
    issue_and_check(vec_isa_pkg::VADD_VX, 5'd2, '0, 5'd1, rand_bits(32));
    issue_and_check(vec_isa_pkg::VADD_VX, 5'd3, '0, 5'd1, rand_bits(32));
    issue_and_check(vec_isa_pkg::VADD_VV, 5'd4, 5'd3, 5'd2, '0);
    issue_and_check(vec_isa_pkg::VSUB_VV, 5'd5, 5'd3, 5'd2, '0);
    issue_and_check(vec_isa_pkg::VAND_VV, 5'd6, 5'd3, 5'd2, '0);
    issue_and_check(vec_isa_pkg::VOR_VV, 5'd7, 5'd3, 5'd2, '0);
    for (int r = 1; r <= 7; r++) begin
      check_reg(r);
    end
  endtask

  task automatic test_tail_undisturbed();
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, 1 + rand_bits(3) % (VLMAX - 1));
    issue_and_check(vec_isa_pkg::VADD_VX, 5'd2, '0, 5'd7, rand_bits(32));
    issue_and_check(vec_isa_pkg::VSUB_VV, 5'd3, 5'd5, 5'd4, '0);
    issue_and_check(vec_isa_pkg::VID, 5'd6, '0, '0, '0);
    check_reg(5'd2);
    check_reg(5'd3);
    check_reg(5'd6);
    // Zero length leaves the register alone
    issue_and_check(vec_isa_pkg::VSETVL, '0, '0, '0, 32'd0);
    issue_and_check(vec_isa_pkg::VADD_VX, 5'd4, '0, 5'd1, rand_bits(32));
    check_reg(5'd4);
  endtask

  task automatic test_resp_backpressure();
    vec_isa_pkg::acc_req_t req;
    vec_isa_pkg::elem_t    result;
    int unsigned           n_resp;
    req.op     = vec_isa_pkg::VEXT_X;
    req.vd     = '0;
    req.vs1    = '0;
    req.vs2    = 5'd3;
    req.scalar = 32'd5;
    @(posedge clk);
    acc_resp_ready <= 1'b0;
    drive_req(req);
    wait_resp(result);
    check_value("acc_resp_o.result", result, model_vrf[3][5]);
    repeat (6) begin
      @(negedge clk);
      check_value("acc_resp_valid_o", acc_resp_valid, 1'b1);
      check_value("acc_resp_o.result", acc_resp.result, model_vrf[3][5]);
      check_value("acc_req_ready_o", acc_req_ready, 1'b0);
    end
    @(posedge clk);
    acc_resp_ready <= 1'b1;
    n_resp = 0;
    repeat (8) begin
      @(negedge clk);
      if (acc_resp_valid && acc_resp_ready) begin
        n_resp++;
      end
    end
    check_value("response count", n_resp, 1);
    issue_and_check(vec_isa_pkg::VEXT_X, '0, '0, 5'd7, 32'd2);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    model_vl       = 0;
    for (int r = 0; r < vec_isa_pkg::NrVRegs; r++) begin
      for (int i = 0; i < VLMAX; i++) begin
        model_vrf[r][i] = '0;
      end
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_setvl_clamp();
    test_full_length_alu();
    test_tail_undisturbed();
    test_resp_backpressure();

    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
source/vec_isa_pkg.sv
source/vec_uarch_pkg.sv
source/vec_lane_vrf.sv
source/vec_lane.sv
source/vec_sequencer.sv
source/vec_dispatcher.sv
source/vec_top.sv
tb/vec_tb.sv

/* Bender.yml */
package:
  name: vec_coproc

sources:
  - source/vec_isa_pkg.sv
  - source/vec_uarch_pkg.sv
  - source/vec_lane_vrf.sv
  - source/vec_lane.sv
  - source/vec_sequencer.sv
  - source/vec_dispatcher.sv
  - source/vec_top.sv
  - target: simulation
    files:
      - tb/vec_tb.sv
